//--- source/ntm_settings.svh
// NTM arithmetic widths
`ifndef NTM_SETTINGS_SVH
`define NTM_SETTINGS_SVH

////////////////////////////////////////////////////////////////////////////
// Datapath
////////////////////////////////////////////////////////////////////////////

// Operands, modulus and products
`define NTM_DATA_WIDTH 16

////////////////////////////////////////////////////////////////////////////
// Control
////////////////////////////////////////////////////////////////////////////

// Matrix sizes and row/column counters
`define NTM_INDEX_WIDTH 8

`endif

//--- source/ntm_pkg.sv
// NTM arithmetic types
`include "ntm_settings.svh"

package ntm_pkg;

  // Operand, modulus or product
  typedef logic [`NTM_DATA_WIDTH-1:0] data_t;

  // Matrix dimension or loop index
  typedef logic [`NTM_INDEX_WIDTH-1:0] index_t;

  // Scalar modular multiplier
  typedef enum logic [1:0] {
    SCALAR_IDLE,
    SCALAR_SHIFT,
    SCALAR_HOLD
  } scalar_state_t;

  // Vector multiplier, one element per pass
  typedef enum logic [1:0] {
    VECTOR_IDLE,
    VECTOR_FETCH,
    VECTOR_MULTIPLY,
    VECTOR_EMIT
  } vector_state_t;

  // Matrix controller
  typedef enum logic [1:0] {
    MATRIX_IDLE,
    MATRIX_CONFIG_ACK,
    MATRIX_ROW_START,
    MATRIX_ROW_RUN
  } matrix_state_t;

endpackage

//--- source/ntm_scalar_if.sv
// Scalar multiplier link
interface ntm_scalar_if;

  // Request side, held stable while req is high
  logic           req;
  ntm_pkg::data_t a;
  ntm_pkg::data_t b;
  ntm_pkg::data_t modulo;

  // Response side, held until req drops
  logic           ack;
  ntm_pkg::data_t product;

  // Vector multiplier end
  modport client (
    output req, a, b, modulo,
    input  ack, product
  );

  // Modular multiplier end
  modport server (
    input  req, a, b, modulo,
    output ack, product
  );

endinterface

//--- source/ntm_vector_if.sv
// Row multiplier link
interface ntm_vector_if;

  // Row setup, pulse plus values stable for the row
  logic            row_start;
  ntm_pkg::index_t size;
  ntm_pkg::data_t  modulo;

  // Operand pair transfer, four-phase
  logic            in_req;
  ntm_pkg::data_t  a;
  ntm_pkg::data_t  b;
  logic            in_ack;

  // Product transfer, four-phase
  logic            out_req;
  ntm_pkg::data_t  p;
  logic            p_last;
  logic            out_ack;

  // Matrix controller end
  modport controller (
    output row_start, size, modulo,
    output in_req, a, b,
    input  in_ack,
    input  out_req, p, p_last,
    output out_ack
  );

  // Vector multiplier end
  modport vector (
    input  row_start, size, modulo,
    input  in_req, a, b,
    output in_ack,
    output out_req, p, p_last,
    input  out_ack
  );

endinterface

//--- source/ntm_scalar_modular_multiplier.sv
// Scalar modular multiplier
`include "ntm_settings.svh"

module ntm_scalar_modular_multiplier (
  input logic          CLK,
  input logic          RST,
  ntm_scalar_if.server srv
);

  ////////////////////////////////////////////////////////////////////////////
  // Declarations
  ////////////////////////////////////////////////////////////////////////////

  localparam int CNT_W = $clog2(`NTM_DATA_WIDTH);

  ntm_pkg::scalar_state_t state;
  logic [CNT_W-1:0]       bit_cnt;
  logic                   ack_q;

  // Latched operands
  ntm_pkg::data_t         a_q;
  ntm_pkg::data_t         mod_q;
  ntm_pkg::data_t         b_shift;

  // Running remainder, one guard bit above the data
  logic [`NTM_DATA_WIDTH:0] acc;

  // One step of the interleaved reduction
  logic [`NTM_DATA_WIDTH:0] mod_w;
  logic [`NTM_DATA_WIDTH:0] dbl;
  logic [`NTM_DATA_WIDTH:0] dbl_red;
  logic [`NTM_DATA_WIDTH:0] sum;
  logic [`NTM_DATA_WIDTH:0] sum_red;

  logic                     load;

  ////////////////////////////////////////////////////////////////////////////
  // Datapath
  ////////////////////////////////////////////////////////////////////////////

  assign load  = (state == ntm_pkg::SCALAR_IDLE) && srv.req;
  assign mod_w = {1'b0, mod_q};

  // 2r, then bring back below M
  assign dbl     = acc << 1;
  assign dbl_red = (dbl >= mod_w) ? dbl - mod_w : dbl;

  // Add a when the current b bit is set
  assign sum     = dbl_red + (b_shift[`NTM_DATA_WIDTH-1] ? {1'b0, a_q} : '0);
  assign sum_red = (sum >= mod_w) ? sum - mod_w : sum;

  always_ff @(posedge CLK) begin
    if (load) begin
      a_q     <= srv.a;
      b_shift <= srv.b;
      mod_q   <= srv.modulo;
      acc     <= '0;
    end else if (state == ntm_pkg::SCALAR_SHIFT) begin
      // MSB first
      acc     <= sum_red;
      b_shift <= b_shift << 1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Control
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state   <= ntm_pkg::SCALAR_IDLE;
      bit_cnt <= '0;
      ack_q   <= 1'b0;
    end else begin
      case (state)
        ntm_pkg::SCALAR_IDLE: begin
          if (load) begin
            bit_cnt <= CNT_W'(`NTM_DATA_WIDTH - 1);
            state   <= ntm_pkg::SCALAR_SHIFT;
          end
        end
        ntm_pkg::SCALAR_SHIFT: begin
          // Last bit consumed on count zero
          if (bit_cnt == '0) begin
            state <= ntm_pkg::SCALAR_HOLD;
          end else begin
            bit_cnt <= bit_cnt - 1'b1;
          end
        end
        ntm_pkg::SCALAR_HOLD: begin
          // Ack until the client lets go
          if (srv.req) begin
            ack_q <= 1'b1;
          end else begin
            ack_q <= 1'b0;
            state <= ntm_pkg::SCALAR_IDLE;
          end
        end
        default: begin
          state <= ntm_pkg::SCALAR_IDLE;
        end
      endcase
    end
  end

  assign srv.ack     = ack_q;
  // Remainder is below M here, guard bit is zero
  assign srv.product = acc[`NTM_DATA_WIDTH-1:0];

endmodule

//--- source/ntm_vector_integer_multiplier.sv
// Vector element multiplier
module ntm_vector_integer_multiplier (
  input logic          CLK,
  input logic          RST,
  ntm_vector_if.vector ctl,
  ntm_scalar_if.client mul
);

  ////////////////////////////////////////////////////////////////////////////
  // Declarations
  ////////////////////////////////////////////////////////////////////////////

  ntm_pkg::vector_state_t state;
  ntm_pkg::index_t        col;

  // Handshake outputs
  logic                   in_ack_q;
  logic                   mul_req_q;
  logic                   out_req_q;

  // Element payload
  ntm_pkg::data_t         mod_q;
  ntm_pkg::data_t         a_q;
  ntm_pkg::data_t         b_q;
  ntm_pkg::data_t         p_q;

  logic                   row_load;
  logic                   pair_take;
  logic                   prod_take;
  logic                   col_last;

  ////////////////////////////////////////////////////////////////////////////
  // Datapath
  ////////////////////////////////////////////////////////////////////////////

  assign row_load  = (state == ntm_pkg::VECTOR_IDLE) && ctl.row_start;
  assign pair_take = (state == ntm_pkg::VECTOR_FETCH) && !in_ack_q && ctl.in_req;
  assign prod_take = (state == ntm_pkg::VECTOR_MULTIPLY) && mul_req_q && mul.ack;

  // Size is held by the controller for the whole row
  assign col_last  = (col == ctl.size - ntm_pkg::index_t'(1));

  always_ff @(posedge CLK) begin
    if (row_load) begin
      mod_q <= ctl.modulo;
    end
    if (pair_take) begin
      a_q <= ctl.a;
      b_q <= ctl.b;
    end
    // Product kept through the out handshake
    if (prod_take) begin
      p_q <= mul.product;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Element sequencer
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state     <= ntm_pkg::VECTOR_IDLE;
      col       <= '0;
      in_ack_q  <= 1'b0;
      mul_req_q <= 1'b0;
      out_req_q <= 1'b0;
    end else begin
      case (state)
        ntm_pkg::VECTOR_IDLE: begin
          if (row_load) begin
            col   <= '0;
            state <= ntm_pkg::VECTOR_FETCH;
          end
        end
        ntm_pkg::VECTOR_FETCH: begin
          // Accept pair, then wait for req low
          if (pair_take) begin
            in_ack_q <= 1'b1;
          end else if (in_ack_q && !ctl.in_req) begin
            in_ack_q  <= 1'b0;
            mul_req_q <= 1'b1;
            state     <= ntm_pkg::VECTOR_MULTIPLY;
          end
        end
        ntm_pkg::VECTOR_MULTIPLY: begin
          if (prod_take) begin
            mul_req_q <= 1'b0;
          end else if (!mul_req_q && !mul.ack) begin
            // Scalar side idle again
            out_req_q <= 1'b1;
            state     <= ntm_pkg::VECTOR_EMIT;
          end
        end
        ntm_pkg::VECTOR_EMIT: begin
          if (out_req_q && ctl.out_ack) begin
            out_req_q <= 1'b0;
          end else if (!out_req_q && !ctl.out_ack) begin
            // Product fully handed over
            if (col_last) begin
              state <= ntm_pkg::VECTOR_IDLE;
            end else begin
              col   <= col + 1'b1;
              state <= ntm_pkg::VECTOR_FETCH;
            end
          end
        end
        default: begin
          state <= ntm_pkg::VECTOR_IDLE;
        end
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Outputs
  ////////////////////////////////////////////////////////////////////////////

  assign ctl.in_ack  = in_ack_q;
  assign ctl.out_req = out_req_q;
  assign ctl.p       = p_q;
  assign ctl.p_last  = col_last;

  assign mul.req     = mul_req_q;
  assign mul.a       = a_q;
  assign mul.b       = b_q;
  assign mul.modulo  = mod_q;

endmodule

//--- source/ntm_matrix_integer_multiplier.sv
// Matrix element-wise modular multiplier
module ntm_matrix_integer_multiplier (
  input  logic            CLK,
  input  logic            RST,

  // Configuration handshake
  input  logic            start_req,
  output logic            start_ack,
  input  ntm_pkg::data_t  modulo,
  input  ntm_pkg::index_t size_i,
  input  ntm_pkg::index_t size_j,

  // Operand stream, row-major
  input  logic            in_req,
  output logic            in_ack,
  input  ntm_pkg::data_t  data_a,
  input  ntm_pkg::data_t  data_b,

  // Product stream
  output logic            out_req,
  input  logic            out_ack,
  output ntm_pkg::data_t  data_out,
  output logic            out_row_last,
  output logic            out_matrix_last
);

  ////////////////////////////////////////////////////////////////////////////
  // Declarations
  ////////////////////////////////////////////////////////////////////////////

  ntm_pkg::matrix_state_t state;
  ntm_pkg::index_t        row;

  // Last product of the row accepted, waiting for ack low
  logic                   last_seen;

  // Configuration held for the whole operation
  ntm_pkg::data_t         modulo_q;
  ntm_pkg::index_t        size_i_q;
  ntm_pkg::index_t        size_j_q;

  logic                   cfg_load;
  logic                   row_final;
  logic                   row_take;
  logic                   row_done;

  ntm_vector_if vif ();
  ntm_scalar_if sif ();

  ////////////////////////////////////////////////////////////////////////////
  // Row controller
  ////////////////////////////////////////////////////////////////////////////

  assign cfg_load  = (state == ntm_pkg::MATRIX_IDLE) && start_req;
  assign row_final = (row == size_i_q - ntm_pkg::index_t'(1));
  assign row_take  = vif.out_req && vif.p_last && out_ack;
  // Same condition the vector unit uses to go idle
  assign row_done  = last_seen && !vif.out_req && !out_ack;

  always_ff @(posedge CLK) begin
    if (cfg_load) begin
      modulo_q <= modulo;
      size_i_q <= size_i;
      size_j_q <= size_j;
    end
  end

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state     <= ntm_pkg::MATRIX_IDLE;
      start_ack <= 1'b0;
      row       <= '0;
      last_seen <= 1'b0;
    end else begin
      case (state)
        ntm_pkg::MATRIX_IDLE: begin
          if (cfg_load) begin
            start_ack <= 1'b1;
            row       <= '0;
            state     <= ntm_pkg::MATRIX_CONFIG_ACK;
          end
        end
        ntm_pkg::MATRIX_CONFIG_ACK: begin
          // Close the start handshake first
          if (!start_req) begin
            start_ack <= 1'b0;
            state     <= ntm_pkg::MATRIX_ROW_START;
          end
        end
        ntm_pkg::MATRIX_ROW_START: begin
          // One cycle here gives the row_start pulse
          state <= ntm_pkg::MATRIX_ROW_RUN;
        end
        ntm_pkg::MATRIX_ROW_RUN: begin
          if (row_take) begin
            last_seen <= 1'b1;
          end else if (row_done) begin
            last_seen <= 1'b0;
            if (row_final) begin
              state <= ntm_pkg::MATRIX_IDLE;
            end else begin
              row   <= row + 1'b1;
              state <= ntm_pkg::MATRIX_ROW_START;
            end
          end
        end
        default: begin
          state <= ntm_pkg::MATRIX_IDLE;
        end
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Relay to the row multiplier
  ////////////////////////////////////////////////////////////////////////////

  assign vif.row_start = (state == ntm_pkg::MATRIX_ROW_START);
  assign vif.size      = size_j_q;
  assign vif.modulo    = modulo_q;

  // Operands only pass while a row runs
  assign vif.in_req    = in_req && (state == ntm_pkg::MATRIX_ROW_RUN);
  assign vif.a         = data_a;
  assign vif.b         = data_b;
  assign in_ack        = vif.in_ack;

  assign out_req         = vif.out_req;
  assign vif.out_ack     = out_ack;
  assign data_out        = vif.p;
  assign out_row_last    = vif.p_last;
  assign out_matrix_last = vif.p_last && row_final;

  ntm_vector_integer_multiplier i_ntm_vector_integer_multiplier (
    .CLK (CLK),
    .RST (RST),
    .ctl (vif.vector),
    .mul (sif.client)
  );

  ntm_scalar_modular_multiplier i_ntm_scalar_modular_multiplier (
    .CLK (CLK),
    .RST (RST),
    .srv (sif.server)
  );

endmodule

//--- test/ntm_matrix_multiplier_tb.sv
// Matrix multiplier testbench
`include "ntm_settings.svh"

module ntm_matrix_multiplier_tb;

  timeunit 1ns;
  timeprecision 100ps;

  ////////////////////////////////////////////////////////////////////////////
  // Constants and signals
  ////////////////////////////////////////////////////////////////////////////

  localparam int W             = `NTM_DATA_WIDTH;
  localparam int DRIVE_DELAY   = 10;
  localparam int MAX_ACK_DELAY = 4;
  // Elements over all tests, random shapes counted at 5x5
  localparam int TOTAL_ELEMENTS = 2 + 6 + 7 + 12 + 6 * 25 + 7;
  localparam int CYCLE_LIMIT    = TOTAL_ELEMENTS * (W + 12 + MAX_ACK_DELAY) + 200;
  localparam int unsigned SEED  = 32'hd4f34fc9;

  logic            CLK;
  logic            RST;
  logic            start_req;
  logic            start_ack;
  ntm_pkg::data_t  modulo;
  ntm_pkg::index_t size_i;
  ntm_pkg::index_t size_j;
  logic            in_req;
  logic            in_ack;
  ntm_pkg::data_t  data_a;
  ntm_pkg::data_t  data_b;
  logic            out_req;
  logic            out_ack;
  ntm_pkg::data_t  data_out;
  logic            out_row_last;
  logic            out_matrix_last;

  // Operands of the next operation, row-major
  ntm_pkg::data_t  op_a[$];
  ntm_pkg::data_t  op_b[$];

  // Reference model, {matrix_last, row_last, product} per element
  logic [W+1:0]    exp_q[$];
  logic            head_valid;
  ntm_pkg::data_t  head_data;
  logic            head_row_last;
  logic            head_mat_last;

  int              error_count;
  int              tests_run;
  int              tests_failed;
  int              in_sent;
  int              out_taken;
  int              cycle_count;

  ntm_matrix_integer_multiplier i_ntm_matrix_integer_multiplier (
    .CLK             (CLK),
    .RST             (RST),
    .start_req       (start_req),
    .start_ack       (start_ack),
    .modulo          (modulo),
    .size_i          (size_i),
    .size_j          (size_j),
    .in_req          (in_req),
    .in_ack          (in_ack),
    .data_a          (data_a),
    .data_b          (data_b),
    .out_req         (out_req),
    .out_ack         (out_ack),
    .data_out        (data_out),
    .out_row_last    (out_row_last),
    .out_matrix_last (out_matrix_last)
  );

  always #50 CLK = ~CLK;

  // Watchdog
  always @(posedge CLK) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("Timeout: run still busy after %0d cycles", CYCLE_LIMIT);
      $display("Regression failed");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////////////////////

  data_check: assert property (@(posedge CLK) disable iff (RST)
    out_req |-> head_valid && data_out == head_data)
    else begin
      $display("FAILED %0t: data_out %0h, expected %0h (valid %0b)",
               $time, data_out, head_data, head_valid);
      error_count++;
    end

  flag_check: assert property (@(posedge CLK) disable iff (RST)
    out_req |-> out_row_last == head_row_last && out_matrix_last == head_mat_last)
    else begin
      $display("FAILED %0t: flags row %0b matrix %0b, expected row %0b matrix %0b",
               $time, out_row_last, out_matrix_last, head_row_last, head_mat_last);
      error_count++;
    end

  // Product held while the sink stalls
  hold_check: assert property (@(posedge CLK) disable iff (RST)
    out_req && !out_ack |=> out_req && $stable(data_out) && $stable(out_row_last)
      && $stable(out_matrix_last))
    else begin
      $display("FAILED %0t: product outputs changed under back-pressure", $time);
      error_count++;
    end

  // Driver counts a pair as soon as it sees the ack
  order_check: assert property (@(posedge CLK) disable iff (RST)
    $rose(in_ack) |-> in_sent == out_taken + 1)
    else begin
      $display("FAILED %0t: in_ack rose with %0d pairs sent, %0d products taken",
               $time, in_sent, out_taken);
      error_count++;
    end

  start_rise_check: assert property (@(posedge CLK) disable iff (RST)
    $rose(start_req) |=> start_ack)
    else begin
      $display("FAILED %0t: start_ack late after start_req", $time);
      error_count++;
    end

  start_fall_check: assert property (@(posedge CLK) disable iff (RST)
    !start_req && start_ack |=> !start_ack)
    else begin
      $display("FAILED %0t: start_ack held after start_req dropped", $time);
      error_count++;
    end

  ////////////////////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////////////////////

  // Sample and drive point
  task automatic tick();
    @(posedge CLK);
    #DRIVE_DELAY;
  endtask

  function automatic int unsigned rand_range(input int unsigned lo, input int unsigned hi);
    return lo + ($urandom % (hi - lo + 1));
  endfunction

  // Double-width product, then the remainder
  function automatic ntm_pkg::data_t mod_product(input ntm_pkg::data_t a,
                                                 input ntm_pkg::data_t b,
                                                 input ntm_pkg::data_t m);
    logic [2*W-1:0] full;
    full = {{W{1'b0}}, a} * {{W{1'b0}}, b};
    return ntm_pkg::data_t'(full % {{W{1'b0}}, m});
  endfunction

  task automatic add_pair(input int a, input int b);
    op_a.push_back(ntm_pkg::data_t'(a));
    op_b.push_back(ntm_pkg::data_t'(b));
  endtask

  // Operands below the modulus
  task automatic fill_random(input int count, input ntm_pkg::data_t m);
    for (int k = 0; k < count; k++) begin
      op_a.push_back(ntm_pkg::data_t'($urandom % 32'(m)));
      op_b.push_back(ntm_pkg::data_t'($urandom % 32'(m)));
    end
  endtask

  task automatic load_head();
    if (exp_q.size() > 0) begin
      {head_mat_last, head_row_last, head_data} = exp_q[0];
      head_valid = 1'b1;
    end else begin
      head_valid = 1'b0;
    end
  endtask

  task automatic config_handshake(input ntm_pkg::data_t m, input int rows, input int cols);
    modulo    = m;
    size_i    = ntm_pkg::index_t'(rows);
    size_j    = ntm_pkg::index_t'(cols);
    start_req = 1'b1;
    do tick(); while (!start_ack);
    start_req = 1'b0;
    do tick(); while (start_ack);
  endtask

  task automatic send_operands();
    for (int k = 0; k < op_a.size(); k++) begin
      data_a = op_a[k];
      data_b = op_b[k];
      in_req = 1'b1;
      do tick(); while (!in_ack);
      in_req  = 1'b0;
      in_sent = in_sent + 1;
      do tick(); while (in_ack);
    end
  endtask

  // Product sink with a random stall before each ack
  task automatic take_products(input int count, input int delay_max);
    int unsigned delay;
    for (int k = 0; k < count; k++) begin
      do tick(); while (!out_req);
      delay = rand_range(0, delay_max);
      repeat (delay) tick();
      out_ack = 1'b1;
      do tick(); while (out_req);
      out_ack   = 1'b0;
      out_taken = out_taken + 1;
      void'(exp_q.pop_front());
      load_head();
    end
  endtask

  task automatic run_operation(input ntm_pkg::data_t m, input int rows, input int cols,
                               input int delay_max);
    int k;
    exp_q.delete();
    for (int i = 0; i < rows; i++) begin
      for (int j = 0; j < cols; j++) begin
        k = i * cols + j;
        exp_q.push_back({(i == rows - 1) && (j == cols - 1), (j == cols - 1),
                         mod_product(op_a[k], op_b[k], m)});
      end
    end
    in_sent   = 0;
    out_taken = 0;
    load_head();
    config_handshake(m, rows, cols);
    fork
      send_operands();
      take_products(rows * cols, delay_max);
    join
    repeat (2) tick();
    // Nothing more offered once the last element is taken
    assert (!out_req && !in_ack && !start_ack)
      else begin
        $display("Error: handshake still active after the %0dx%0d matrix", rows, cols);
        error_count++;
      end
    op_a.delete();
    op_b.delete();
  endtask

  task automatic report_test(input string name, input int errors_at_start);
    tests_run++;
    if (error_count == errors_at_start) begin
      $display("Test %0d %s: ok", tests_run, name);
    end else begin
      tests_failed++;
      $display("Test %0d %s: %0d errors", tests_run, name, error_count - errors_at_start);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    int             mark;
    int             rows;
    int             cols;
    ntm_pkg::data_t m;
    int unsigned    seed_dummy;

    CLK = 1'b0;
    RST = 1'b1;
    start_req = 1'b0;
    modulo    = '0;
    size_i    = '0;
    size_j    = '0;
    in_req    = 1'b0;
    data_a    = '0;
    data_b    = '0;
    out_ack   = 1'b0;
    head_valid    = 1'b0;
    head_data     = '0;
    head_row_last = 1'b0;
    head_mat_last = 1'b0;
    error_count  = 0;
    tests_run    = 0;
    tests_failed = 0;
    in_sent      = 0;
    out_taken    = 0;
    cycle_count  = 0;
    seed_dummy   = $urandom(SEED);

    repeat (2) @(posedge CLK);
    #DRIVE_DELAY;
    RST = 1'b0;

    // Reset values, then a small operation for the start handshake
    mark = error_count;
    assert (!start_ack && !in_ack && !out_req)
      else begin
        $display("FAILED %0t: handshake outputs not low after reset", $time);
        error_count++;
      end
    add_pair(3, 5);
    add_pair(6, 6);
    run_operation(ntm_pkg::data_t'(7), 1, 2, 0);
    report_test("reset and start handshake", mark);

    // Corner operands 0, 1 and M-1
    mark = error_count;
    add_pair(0, 5);
    add_pair(1, 250);
    add_pair(250, 250);
    add_pair(17, 0);
    add_pair(250, 1);
    add_pair(123, 200);
    run_operation(ntm_pkg::data_t'(251), 2, 3, 0);
    report_test("fixed 2x3", mark);

    // Flags on a single element and on narrow rows
    mark = error_count;
    add_pair(12, 11);
    run_operation(ntm_pkg::data_t'(13), 1, 1, 0);
    fill_random(6, ntm_pkg::data_t'(97));
    run_operation(ntm_pkg::data_t'(97), 3, 2, 0);
    report_test("row and matrix flags", mark);

    // Stalled sink, largest modulus
    mark = error_count;
    m = ntm_pkg::data_t'(1 << (W - 1));
    fill_random(12, m);
    run_operation(m, 3, 4, MAX_ACK_DELAY);
    report_test("back-pressure", mark);

    mark = error_count;
    for (int n = 0; n < 6; n++) begin
      rows = int'(rand_range(1, 5));
      cols = int'(rand_range(1, 5));
      m    = ntm_pkg::data_t'(rand_range(2, 1 << (W - 1)));
      fill_random(rows * cols, m);
      run_operation(m, rows, cols, 2);
    end
    report_test("random shapes", mark);

    // No gap between operations
    mark = error_count;
    fill_random(4, ntm_pkg::data_t'(3));
    run_operation(ntm_pkg::data_t'(3), 2, 2, 1);
    fill_random(3, ntm_pkg::data_t'(32749));
    run_operation(ntm_pkg::data_t'(32749), 3, 1, 1);
    report_test("back-to-back", mark);

    $display("Tests run %0d, tests failed %0d, check errors %0d",
             tests_run, tests_failed, error_count);
    if (error_count == 0 && tests_failed == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

//--- compile.f
+incdir+source
source/ntm_pkg.sv
source/ntm_scalar_if.sv
source/ntm_vector_if.sv
source/ntm_scalar_modular_multiplier.sv
source/ntm_vector_integer_multiplier.sv
source/ntm_matrix_integer_multiplier.sv
test/ntm_matrix_multiplier_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build with Verilator, run, and look for the pass line in the output.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
  -f compile.f --top-module ntm_matrix_multiplier_tb -o sim_tb \
  && sim_out="$(./obj_dir/sim_tb)" \
  && printf '%s\n' "$sim_out" \
  && printf '%s\n' "$sim_out" | grep -qx 'Regression passed' \
  && echo "Simulation finished without errors" \
  || { echo "Simulation reported errors or did not build"; exit 1; }
